//--- src/vga_defines.svh
`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// 800x600 at 60 Hz with a 40 MHz pixel clock
`define HOR_PIXELS   11'd800     // visible pixels per line
`define HOR_TOTAL    11'd1056    // full line incl. porches
`define HSYNC_START  11'd840     // first hsync count
`define HSYNC_LEN    11'd128     // hsync width

`define VER_PIXELS   11'd600     // visible lines
`define VER_TOTAL    11'd628     // full frame
`define VSYNC_START  11'd601     // first vsync line
`define VSYNC_LEN    11'd4       // vsync height

// open window around the title text
`define TITLE_X_MIN  11'd160
`define TITLE_X_MAX  11'd650
`define TITLE_Y_MIN  11'd250
`define TITLE_Y_MAX  11'd320

`define BLOCK_SIZE   11'd32      // side of the player block

// apb word offsets
`define REG_MODE     8'h00
`define REG_POS      8'h04
`define REG_COLOR    8'h08

`endif

//--- src/vga_pkg.sv
package vga_pkg;

    typedef logic [10:0] coord_t;        // pixel column or line number
    typedef logic [11:0] rgb_t;          // r in 11:8, g in 7:4, b in 3:0
    typedef logic [7:0]  apb_addr_t;     // byte address into the reg block
    typedef logic [31:0] apb_data_t;     // apb data word

    // selects what the overlay stage shows
    typedef enum logic {
        MODE_START = 1'b0,               // title page
        MODE_PLAY  = 1'b1                // playfield passes through
    } screen_mode_t;

    // one pixel beat as it moves down the video pipeline
    typedef struct packed {
        coord_t hcount;                  // column of this beat
        coord_t vcount;                  // line of this beat
        logic   hsync;                   // active high
        logic   vsync;                   // active high
        logic   hblnk;                   // outside visible columns
        logic   vblnk;                   // outside visible lines
        rgb_t   rgb;                     // pixel colour
    } vga_bus_t;

endpackage

//--- src/vga_timing.sv
`include "vga_defines.svh"

module vga_timing (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_bus_t bus
);

    import vga_pkg::*;

    coord_t   hcount_nxt;              // counters for the next beat
    coord_t   vcount_nxt;
    logic     line_end;                // last column of the line
    logic     frame_end;               // last line of the frame
    vga_bus_t bus_nxt;

    // the output register doubles as the counter state
    assign line_end  = (bus.hcount == `HOR_TOTAL - 11'd1);
    assign frame_end = (bus.vcount == `VER_TOTAL - 11'd1);

    always_comb begin
        if (line_end) begin
            hcount_nxt = '0;                                // wrap to column 0
        end else begin
            hcount_nxt = bus.hcount + 11'd1;
        end

        if (line_end && frame_end) begin
            vcount_nxt = '0;                                // new frame
        end else if (line_end) begin
            vcount_nxt = bus.vcount + 11'd1;                // next line
        end else begin
            vcount_nxt = bus.vcount;                        // hold within the line
        end
    end

    // flags come from the next counts so they land with them
    always_comb begin
        bus_nxt.hcount = hcount_nxt;
        bus_nxt.vcount = vcount_nxt;
        bus_nxt.hsync  = (hcount_nxt >= `HSYNC_START)
                      && (hcount_nxt <  `HSYNC_START + `HSYNC_LEN);
        bus_nxt.vsync  = (vcount_nxt >= `VSYNC_START)
                      && (vcount_nxt <  `VSYNC_START + `VSYNC_LEN);
        bus_nxt.hblnk  = (hcount_nxt >= `HOR_PIXELS);      // right porch onwards
        bus_nxt.vblnk  = (vcount_nxt >= `VER_PIXELS);      // bottom porch onwards
        bus_nxt.rgb    = '0;                                // colour added downstream
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus <= '0;                                      // counters and flags cleared
        end else begin
            bus <= bus_nxt;
        end
    end

endmodule

//--- src/screen_regs.sv
`include "vga_defines.svh"

module screen_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::apb_addr_t    paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  vga_pkg::apb_data_t    pwdata,
    output vga_pkg::apb_data_t    prdata,
    output logic                  pready,
    output logic                  pslverr,
    output vga_pkg::screen_mode_t mode,
    output vga_pkg::coord_t       block_x,
    output vga_pkg::coord_t       block_y,
    output vga_pkg::rgb_t         block_rgb
);

    import vga_pkg::*;

    logic      setup_phase;            // first cycle of a transfer
    logic      access_phase;           // second cycle, data moves here
    logic      addr_hit;               // offset maps to a register
    apb_data_t rd_data;                // read mux output

    assign setup_phase  = psel & ~penable;
    assign access_phase = psel & penable;
    assign addr_hit     = (paddr == `REG_MODE) | (paddr == `REG_POS)
                        | (paddr == `REG_COLOR);

    assign pready  = access_phase;                          // zero wait states
    assign pslverr = access_phase & ~addr_hit;              // unmapped offset

    always_comb begin
        case (paddr)
            `REG_MODE:  rd_data = {31'd0, mode};
            `REG_POS:   rd_data = {5'd0, block_y, 5'd0, block_x};  // y high, x low
            `REG_COLOR: rd_data = {20'd0, block_rgb};
            default:    rd_data = '0;                       // holes read as zero
        endcase
    end

    // writes take effect at the edge closing the access phase
    always_ff @(posedge clk) begin
        if (rst) begin
            mode      <= MODE_START;                        // power up on the title page
            block_x   <= '0;
            block_y   <= '0;
            block_rgb <= 12'hFFF;                           // white block
        end else if (access_phase && pwrite) begin
            case (paddr)
                `REG_MODE: begin
                    mode <= screen_mode_t'(pwdata[0]);
                end
                `REG_POS: begin
                    block_x <= pwdata[10:0];
                    block_y <= pwdata[26:16];
                end
                `REG_COLOR: begin
                    block_rgb <= pwdata[11:0];
                end
                default: begin
                end
            endcase
        end
    end

    // read data captured in setup so it is stable during access
    always_ff @(posedge clk) begin
        if (rst) begin
            prdata <= '0;
        end else if (setup_phase && !pwrite) begin
            prdata <= rd_data;
        end
    end

endmodule

//--- src/playfield_draw.sv
`include "vga_defines.svh"

module playfield_draw (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::coord_t   block_x,
    input  vga_pkg::coord_t   block_y,
    input  vga_pkg::rgb_t     block_rgb,
    input  vga_pkg::vga_bus_t bus_in,
    output vga_pkg::vga_bus_t bus_out
);

    import vga_pkg::*;

    logic [11:0] x_end;                // one past the right edge, no wrap
    logic [11:0] y_end;                // one past the bottom edge
    logic        in_block;             // beat lies on the block square
    rgb_t        rgb_nxt;
    vga_bus_t    bus_nxt;

    assign x_end = {1'b0, block_x} + {1'b0, `BLOCK_SIZE};
    assign y_end = {1'b0, block_y} + {1'b0, `BLOCK_SIZE};

    assign in_block = (bus_in.hcount >= block_x)
                   && ({1'b0, bus_in.hcount} < x_end)
                   && (bus_in.vcount >= block_y)
                   && ({1'b0, bus_in.vcount} < y_end);

    always_comb begin
        if (bus_in.hblnk || bus_in.vblnk) begin
            rgb_nxt = 12'h000;                              // black outside the picture
        end else if (in_block) begin
            rgb_nxt = block_rgb;
        end else begin
            rgb_nxt = 12'h222;                              // dark grey field
        end
    end

    always_comb begin
        bus_nxt     = bus_in;                               // timing fields ride along
        bus_nxt.rgb = rgb_nxt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_nxt;
        end
    end

endmodule

//--- src/start_screen.sv
`include "vga_defines.svh"

module start_screen (
    input  logic                  clk,
    input  logic                  rst,
    input  vga_pkg::screen_mode_t mode,
    input  vga_pkg::vga_bus_t     bus_in,
    output vga_pkg::vga_bus_t     bus_out
);

    import vga_pkg::*;

    rgb_t     rgb_nxt;
    vga_bus_t bus_nxt;

    // half-open box test, right and bottom edges excluded
    function automatic logic in_rect(input coord_t x, input coord_t y,
                                     input int x0, input int x1,
                                     input int y0, input int y1);
        return (x >= x0) && (x < x1) && (y >= y0) && (y < y1);
    endfunction

    // "START GAME" built from 10 pixel strokes, black ink on yellow
    function automatic rgb_t glyph_rgb(input coord_t x, input coord_t y);
        logic ink;
        ink = 1'b0;
        ink |= in_rect(x, y, 215, 245, 260, 270);           // S top
        ink |= in_rect(x, y, 215, 225, 270, 290);           // S upper left
        ink |= in_rect(x, y, 215, 245, 280, 290);           // S middle
        ink |= in_rect(x, y, 235, 245, 290, 310);           // S lower right
        ink |= in_rect(x, y, 215, 245, 300, 310);           // S bottom
        ink |= in_rect(x, y, 255, 295, 260, 270);           // T bar
        ink |= in_rect(x, y, 270, 280, 270, 310);           // T stem
        ink |= in_rect(x, y, 300, 310, 270, 310);           // A left leg
        ink |= in_rect(x, y, 320, 330, 270, 310);           // A right leg
        ink |= in_rect(x, y, 310, 320, 260, 270);           // A top
        ink |= in_rect(x, y, 310, 320, 280, 290);           // A crossbar
        ink |= in_rect(x, y, 340, 350, 260, 310);           // R stem
        ink |= in_rect(x, y, 350, 360, 260, 270);           // R top
        ink |= in_rect(x, y, 360, 370, 270, 290);           // R bowl side
        ink |= in_rect(x, y, 350, 370, 280, 290);           // R waist
        ink |= in_rect(x, y, 355, 365, 290, 300);           // R leg upper
        ink |= in_rect(x, y, 360, 370, 300, 310);           // R leg lower
        ink |= in_rect(x, y, 375, 415, 260, 270);           // second T bar
        ink |= in_rect(x, y, 390, 400, 270, 310);           // second T stem
        ink |= in_rect(x, y, 435, 465, 260, 270);           // G top
        ink |= in_rect(x, y, 435, 445, 270, 310);           // G left
        ink |= in_rect(x, y, 445, 465, 300, 310);           // G bottom
        ink |= in_rect(x, y, 455, 465, 280, 290);           // G inner hook
        ink |= in_rect(x, y, 455, 465, 290, 310);           // G lower right
        ink |= in_rect(x, y, 475, 485, 270, 310);           // second A left leg
        ink |= in_rect(x, y, 495, 505, 270, 310);           // second A right leg
        ink |= in_rect(x, y, 485, 495, 260, 270);           // second A top
        ink |= in_rect(x, y, 485, 495, 280, 290);           // second A crossbar
        ink |= in_rect(x, y, 515, 525, 260, 310);           // M left
        ink |= in_rect(x, y, 545, 555, 260, 310);           // M right
        ink |= in_rect(x, y, 525, 530, 270, 280);           // M left slope
        ink |= in_rect(x, y, 540, 545, 270, 280);           // M right slope
        ink |= in_rect(x, y, 530, 540, 280, 290);           // M centre
        ink |= in_rect(x, y, 565, 575, 260, 310);           // E stem
        ink |= in_rect(x, y, 575, 605, 260, 270);           // E top
        ink |= in_rect(x, y, 575, 605, 280, 290);           // E middle
        ink |= in_rect(x, y, 575, 605, 300, 310);           // E bottom
        return ink ? 12'h000 : 12'hFF0;
    endfunction

    always_comb begin
        if (mode == MODE_PLAY) begin
            rgb_nxt = bus_in.rgb;                           // playfield shows through
        end else if (bus_in.vblnk || bus_in.hblnk) begin
            rgb_nxt = 12'h000;
        end else if (bus_in.vcount == 11'd0) begin
            rgb_nxt = 12'hFF0;                              // yellow top row
        end else if (bus_in.vcount == `VER_PIXELS - 11'd1) begin
            rgb_nxt = 12'hF00;                              // red bottom row
        end else if (bus_in.hcount == 11'd0) begin
            rgb_nxt = 12'h0F0;                              // green left column
        end else if (bus_in.hcount == `HOR_PIXELS - 11'd1) begin
            rgb_nxt = 12'h00F;                              // blue right column
        end else if ((bus_in.vcount > `TITLE_Y_MIN) && (bus_in.vcount < `TITLE_Y_MAX)
                  && (bus_in.hcount > `TITLE_X_MIN) && (bus_in.hcount < `TITLE_X_MAX)) begin
            rgb_nxt = glyph_rgb(bus_in.hcount, bus_in.vcount);
        end else begin
            rgb_nxt = 12'h0F0;                              // green backdrop
        end
    end

    always_comb begin
        bus_nxt     = bus_in;                               // hblnk included
        bus_nxt.rgb = rgb_nxt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_out <= '0;
        end else begin
            bus_out <= bus_nxt;
        end
    end

endmodule

//--- src/vga_top.sv
module vga_top (
    input  logic               clk,
    input  logic               rst,
    input  vga_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  vga_pkg::apb_data_t pwdata,
    output vga_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output vga_pkg::vga_bus_t  vga_out
);

    import vga_pkg::*;

    vga_bus_t     bus_timing;          // counters and sync, no colour yet
    vga_bus_t     bus_field;           // playfield painted
    screen_mode_t mode;
    coord_t       block_x;
    coord_t       block_y;
    rgb_t         block_rgb;

    vga_timing u_timing (
        .clk (clk),
        .rst (rst),
        .bus (bus_timing)
    );

    screen_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .mode      (mode),
        .block_x   (block_x),
        .block_y   (block_y),
        .block_rgb (block_rgb)
    );

    playfield_draw u_field (
        .clk       (clk),
        .rst       (rst),
        .block_x   (block_x),
        .block_y   (block_y),
        .block_rgb (block_rgb),
        .bus_in    (bus_timing),
        .bus_out   (bus_field)
    );

    // last stage, two beats behind the counters
    start_screen u_start (
        .clk     (clk),
        .rst     (rst),
        .mode    (mode),
        .bus_in  (bus_field),
        .bus_out (vga_out)
    );

endmodule

//--- verif/vga_tb.sv
`include "vga_defines.svh"

module vga_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import vga_pkg::*;

    localparam int FRAME_CYCLES   = int'(`HOR_TOTAL) * int'(`VER_TOTAL);  // 663168 beats
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 1000;

    logic      clk;
    logic      rst;
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
    vga_bus_t  vga_out;

    screen_mode_t model_mode;          // host copy of the registers
    int           model_x;
    int           model_y;
    rgb_t         model_rgb;

    logic [15:0] lfsr;                 // galois state
    logic        checking;             // compare process armed
    int          skip_cnt;             // rgb compares still to skip
    int          error_count;
    int          cycle_cnt;
    int          hs_cnt;               // hsync beats this line
    int          vs_cnt;               // vsync lines this frame
    int          next_h;               // hcount due on the next beat
    int          next_v;               // vcount due on the next beat
    logic        seq_armed;            // counter sequence check live
    apb_data_t   rd_data;
    logic        rd_err;

    // "START GAME" strokes as x0, x1, y0, y1, half open
    int glyph_box [37][4] = '{
        '{215, 245, 260, 270}, '{215, 225, 270, 290}, '{215, 245, 280, 290},
        '{235, 245, 290, 310}, '{215, 245, 300, 310}, '{255, 295, 260, 270},
        '{270, 280, 270, 310}, '{300, 310, 270, 310}, '{320, 330, 270, 310},
        '{310, 320, 260, 270}, '{310, 320, 280, 290}, '{340, 350, 260, 310},
        '{350, 360, 260, 270}, '{360, 370, 270, 290}, '{350, 370, 280, 290},
        '{355, 365, 290, 300}, '{360, 370, 300, 310}, '{375, 415, 260, 270},
        '{390, 400, 270, 310}, '{435, 465, 260, 270}, '{435, 445, 270, 310},
        '{445, 465, 300, 310}, '{455, 465, 280, 290}, '{455, 465, 290, 310},
        '{475, 485, 270, 310}, '{495, 505, 270, 310}, '{485, 495, 260, 270},
        '{485, 495, 280, 290}, '{515, 525, 260, 310}, '{545, 555, 260, 310},
        '{525, 530, 270, 280}, '{540, 545, 270, 280}, '{530, 540, 280, 290},
        '{565, 575, 260, 310}, '{575, 605, 260, 270}, '{575, 605, 280, 290},
        '{575, 605, 300, 310}
    };

    vga_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .vga_out (vga_out)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                                  // 8 ns period
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0d ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);         // taps 16,14,13,11
    endfunction

    // one lfsr step per bit taken
    task automatic take_random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic rgb_t expected_rgb(input int h, input int v, input logic blank);
        rgb_t rgb;
        logic ink;
        int   i;
        ink = 1'b0;
        if (blank) begin
            rgb = 12'h000;
        end else if (model_mode == MODE_PLAY) begin
            if (h >= model_x && h < model_x + `BLOCK_SIZE
                && v >= model_y && v < model_y + `BLOCK_SIZE) begin
                rgb = model_rgb;
            end else begin
                rgb = 12'h222;                                  // grey field
            end
        end else if (v == 0) begin
            rgb = 12'hFF0;
        end else if (v == `VER_PIXELS - 1) begin
            rgb = 12'hF00;
        end else if (h == 0) begin
            rgb = 12'h0F0;
        end else if (h == `HOR_PIXELS - 1) begin
            rgb = 12'h00F;
        end else if (v > `TITLE_Y_MIN && v < `TITLE_Y_MAX
                     && h > `TITLE_X_MIN && h < `TITLE_X_MAX) begin
            for (i = 0; i < 37; i++) begin
                if (h >= glyph_box[i][0] && h < glyph_box[i][1]
                    && v >= glyph_box[i][2] && v < glyph_box[i][3]) begin
                    ink = 1'b1;
                end
            end
            rgb = ink ? 12'h000 : 12'hFF0;                      // black letters on yellow
        end else begin
            rgb = 12'h0F0;
        end
        return rgb;
    endfunction

    // two cycle transfer, register lands at the edge ending access
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;                                         // access phase
        @(negedge clk);
        check_value(pready, 1'b1, "pready in write access");
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        case (addr)
            `REG_MODE: begin
                model_mode = screen_mode_t'(data[0]);
            end
            `REG_POS: begin
                model_x = data[10:0];
                model_y = data[26:16];
            end
            `REG_COLOR: begin
                model_rgb = data[11:0];
            end
            default: begin
            end
        endcase
        skip_cnt = 3;                                           // pipeline still shows old values
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            output logic err);
        @(posedge clk);
        #1;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        check_value(pready, 1'b1, "pready in read access");
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_random_block();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] c;
        take_random_bits(10, x);
        take_random_bits(10, y);
        take_random_bits(12, c);
        x = x % 769;                                            // square stays on screen
        y = y % 569;
        apb_write(`REG_POS, {5'd0, y[10:0], 5'd0, x[10:0]});
        apb_write(`REG_COLOR, {20'd0, c[11:0]});
    endtask

    // returns at the first beat of vertical blanking on the output
    task automatic wait_vblank_start();
        @(negedge clk);
        while (vga_out.vblnk) begin
            @(negedge clk);
        end
        while (!vga_out.vblnk) begin
            @(negedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (checking) begin
            check_value(vga_out.hblnk, vga_out.hcount >= `HOR_PIXELS, "hblnk");
            check_value(vga_out.vblnk, vga_out.vcount >= `VER_PIXELS, "vblnk");
            check_value(vga_out.hsync, (vga_out.hcount >= `HSYNC_START)
                        && (vga_out.hcount < `HSYNC_START + `HSYNC_LEN), "hsync");
            check_value(vga_out.vsync, (vga_out.vcount >= `VSYNC_START)
                        && (vga_out.vcount < `VSYNC_START + `VSYNC_LEN), "vsync");
            if (seq_armed) begin
                check_value(vga_out.hcount, next_h, "hcount sequence");
                check_value(vga_out.vcount, next_v, "vcount sequence");
            end
            if (vga_out.hcount == `HOR_TOTAL - 11'd1) begin
                next_h = 0;                                     // line wraps
                if (vga_out.vcount == `VER_TOTAL - 11'd1) begin
                    next_v = 0;
                end else begin
                    next_v = int'(vga_out.vcount) + 1;
                end
            end else begin
                next_h = int'(vga_out.hcount) + 1;
                next_v = vga_out.vcount;
            end
            if (vga_out.hcount == 11'd0) begin
                hs_cnt = 0;                                     // new line
                if (vga_out.vcount == 11'd0) begin
                    vs_cnt = 0;
                end
                if (vga_out.vsync) begin
                    vs_cnt++;
                end
                if (vga_out.vcount == `VER_TOTAL - 11'd1) begin
                    check_value(vs_cnt, `VSYNC_LEN, "vsync lines per frame");
                end
            end
            if (vga_out.hsync) begin
                hs_cnt++;
            end
            if (vga_out.hcount == `HOR_TOTAL - 11'd1) begin
                check_value(hs_cnt, `HSYNC_LEN, "hsync beats per line");
            end
            if (skip_cnt > 0) begin
                skip_cnt--;
            end else begin
                check_value(vga_out.rgb,
                            expected_rgb(vga_out.hcount, vga_out.vcount,
                                         vga_out.hblnk | vga_out.vblnk),
                            $sformatf("rgb at x=%0d y=%0d", vga_out.hcount, vga_out.vcount));
                seq_armed = 1'b1;                               // reset beats are behind us
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped by the cycle limit");
    end

    initial begin
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        model_mode  = MODE_START;                               // reset values of the regs
        model_x     = 0;
        model_y     = 0;
        model_rgb   = 12'hFFF;
        lfsr        = 16'd80;
        checking    = 1'b0;
        skip_cnt    = 0;
        error_count = 0;
        hs_cnt      = 0;
        vs_cnt      = 0;
        next_h      = 0;
        next_v      = 0;
        seq_armed   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst      = 1'b0;
        skip_cnt = 3;
        checking = 1'b1;

        // register defaults and an unmapped offset
        apb_read(`REG_MODE, rd_data, rd_err);
        check_value(rd_data, MODE_START, "mode after reset");
        check_value(rd_err, 1'b0, "pslverr on mode read");
        apb_read(`REG_POS, rd_data, rd_err);
        check_value(rd_data, 32'd0, "position after reset");
        apb_read(`REG_COLOR, rd_data, rd_err);
        check_value(rd_data, 32'hFFF, "colour after reset");
        apb_read(8'h0C, rd_data, rd_err);
        check_value(rd_data, 32'd0, "read of unmapped offset");
        check_value(rd_err, 1'b1, "pslverr on unmapped offset");
        @(negedge clk);
        check_value(pslverr, 1'b0, "pslverr after access");
        check_value(pready, 1'b0, "pready after access");

        wait_vblank_start();                                    // title frame checked

        apb_write(`REG_MODE, MODE_PLAY);
        write_random_block();
        apb_read(`REG_POS, rd_data, rd_err);
        check_value(rd_data, (model_y << 16) | model_x, "position readback");
        wait_vblank_start();                                    // first play frame

        write_random_block();
        wait_vblank_start();
        apb_write(`REG_MODE, MODE_START);
        wait_vblank_start();                                    // back on the title page

        checking = 1'b0;
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/vga_pkg.sv
src/vga_timing.sv
src/screen_regs.sv
src/playfield_draw.sv
src/start_screen.sv
src/vga_top.sv
verif/vga_tb.sv
